/* verif/opx_cases.txt */
// One case per line in hex: instruction word, expected result, expected rd
// Fields: op 31:29, rd 28:24, ra 23:19, rb 18:14, imm 13:0
// Back to back cases, forwarding from execute and write-back
C1000123 00000123 01
C2003FFF FFFFFFFF 02
03088000 00000122 03
24184000 FFFFFFFF 04
E5011F00 00001F00 05
46288000 00001F00 06
67284000 00001F23 07
88398000 00000023 08
C9020004 00000004 09
AA3A4000 0001F230 0A
// Register zero write dropped, then read as zero
C0080005 00000128 00
0B004000 00000123 0B
// Same destination twice, execute wins
CC000010 00000010 0C
CC000020 00000020 0C
0D630000 00000040 0D
2E034000 FFFFFFC0 0E
// Negative immediates with rb matching a pending destination
CF73BFC0 FFFFFF80 0F
F0782AAA FFFFFFAA 10
5180C000 00000122 11
92884000 00000001 12
// Later cases with random input gaps
B3148000 FFFFFFFE 13
34988000 FFFFFFFF 14
15A4C000 FFFFFFFD 15
96AD0000 00000002 16
B70D8000 0000048C 17
78B94000 00001F8C 18
D9C61000 00002F8C 19
5ACE0000 00000F8C 1A
20D64000 FFFFE000 00
1B068000 00000F8C 1B
DC000007 00000007 1C
DCE00008 0000000F 1C
BDDF0000 07C60000 1D
FEEF4055 07C60055 1E
9FF74000 00000055 1F
01FFC000 000000AA 01
22080000 000000AA 02
43008000 00000000 03
64184000 000000AA 04
05208000 00000154 05

/* files.f */
hdl/opx_pkg.sv
hdl/opx_regfile.sv
hdl/opx_issue_stage.sv
hdl/opx_fwd_ctrl.sv
hdl/opx_operand_mux.sv
hdl/opx_exec_stage.sv
hdl/opx_core_top.sv
verif/opx_tb.sv

/* Bender.yml */
package:
  name: opx_core

sources:
  - target: rtl
    files:
      - hdl/opx_pkg.sv
      - hdl/opx_regfile.sv
      - hdl/opx_issue_stage.sv
      - hdl/opx_fwd_ctrl.sv
      - hdl/opx_operand_mux.sv
      - hdl/opx_exec_stage.sv
      - hdl/opx_core_top.sv
  - target: test
    files:
      - hdl/opx_pkg.sv
      - hdl/opx_regfile.sv
      - hdl/opx_issue_stage.sv
      - hdl/opx_fwd_ctrl.sv
      - hdl/opx_operand_mux.sv
      - hdl/opx_exec_stage.sv
      - hdl/opx_core_top.sv
      - verif/opx_tb.sv

/* verif/opx_tb.sv */
// Testbench for the execute pipeline, cases and expected results read from a data file
`timescale 1ns/10ps

module opx_tb;
	import opx_pkg::*;

	localparam int max_cases    = 64;
	localparam int seed         = 14166;
	localparam int reset_cycles = 10;
	// Cases before this index run back to back for forwarding
	localparam int gap_start    = 20;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_ready;
	logic [instr_w-1:0]   in_instr;
	logic                 out_valid;
	logic                 out_ready;
	logic [data_w-1:0]    out_result;
	logic [reg_idx_w-1:0] out_rd;

	// Three words per case: instruction, result, destination
	logic [31:0]          case_mem [0:3*max_cases-1];
	// Expected outputs of accepted instructions, oldest first
	logic [data_w-1:0]    exp_result_q [$];
	logic [reg_idx_w-1:0] exp_rd_q [$];

	int                   num_cases;
	int                   checked;
	int                   errors;
	int                   cycles;
	int                   limit;
	int unsigned          rnd;
	logic                 case_ok;
	// Output seen blocked on the last edge
	logic                 hold_pending;
	logic [data_w-1:0]    held_result;
	logic [reg_idx_w-1:0] held_rd;

	opx_core_top #(.DATA_W(data_w)) i_opx_core_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_instr  (in_instr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_result(out_result),
		.out_rd    (out_rd)
	);

	always #5 clk = ~clk;

	// Wrong value check with hex report
	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] expected, inout logic ok);
		assert (got === expected) else begin
			$display("ERROR %s: got %h, expected %h", name, got, expected);
			errors++;
			ok = 1'b0;
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_instr     = '0;
		out_ready    = 1'b0;
		hold_pending = 1'b0;
		held_result  = '0;
		held_rd      = '0;
		case_ok      = 1'b1;
		checked      = 0;
		errors       = 0;
		cycles       = 0;
		num_cases    = 0;
		rnd          = $urandom(seed);
		$readmemh("verif/opx_cases.txt", case_mem);
		// Cases end at the first unfilled entry
		while (num_cases < max_cases && !$isunknown(case_mem[3*num_cases])) begin
			num_cases++;
		end
		limit = 20 * num_cases + reset_cycles;
		assert (num_cases > 0) else begin
			$display("Case file holds no cases");
			errors++;
		end
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < num_cases; i++) begin
			// Occasional bubble in the later cases
			rnd = $urandom;
			if (i >= gap_start && (rnd % 4) == 0) begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_valid <= 1'b1;
			in_instr <= case_mem[3*i];
			@(posedge clk);
			// Held until the issue stage takes it
			while (!in_ready) begin
				@(posedge clk);
			end
			exp_result_q.push_back(case_mem[3*i+1]);
			exp_rd_q.push_back(case_mem[3*i+2][reg_idx_w-1:0]);
		end
		in_valid <= 1'b0;
		wait (checked == num_cases);
		// Pipeline is empty once the last result has left
		@(posedge clk);
		assert (!out_valid) else begin
			$display("Extra result after the last case");
			errors++;
		end
		$display("Cases %0d, checked %0d, errors %0d", num_cases, checked, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	////////////////////////////////////////
	// Output side and checking
	////////////////////////////////////////

	always @(posedge clk) begin
		if (rst_n) begin
			// Blocked output must not move
			if (hold_pending) begin
				assert (out_valid) else begin
					$display("Output valid dropped before the result was taken");
					errors++;
				end
				case_ok = 1'b1;
				compare_value("out_result (held)", out_result, held_result, case_ok);
				compare_value("out_rd (held)", 32'(out_rd), 32'(held_rd), case_ok);
			end
			if (out_valid && out_ready) begin
				assert (exp_result_q.size() > 0) else begin
					$display("Result appeared with no case pending");
					errors++;
				end
				if (exp_result_q.size() > 0) begin
					case_ok = 1'b1;
					compare_value("out_result", out_result, exp_result_q.pop_front(), case_ok);
					compare_value("out_rd", 32'(out_rd), 32'(exp_rd_q.pop_front()), case_ok);
					$display("Case %0d rd %0d result %h %s", checked, out_rd, out_result,
						case_ok ? "ok" : "wrong");
					checked++;
				end
			end
			hold_pending = out_valid && !out_ready;
			held_result  = out_result;
			held_rd      = out_rd;
			// Random back-pressure, ready two cycles in three
			out_ready <= ($urandom % 3) != 0;
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles with %0d of %0d cases checked",
				cycles, checked, num_cases);
			$display("Test failed");
			$finish;
		end
	end

endmodule

/* hdl/opx_core_top.sv */
// Top level of the integer execute pipeline joining issue, operands and execute
`timescale 1ns/10ps

module opx_core_top #(
	parameter int DATA_W = opx_pkg::data_w
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Input handshake
	input  logic                          in_valid,
	output logic                          in_ready,
	input  logic [opx_pkg::instr_w-1:0]   in_instr,
	// Output handshake
	output logic                          out_valid,
	input  logic                          out_ready,
	output logic [DATA_W-1:0]             out_result,
	output logic [opx_pkg::reg_idx_w-1:0] out_rd
);
	import opx_pkg::*;

	////////////////////////////////////////
	// Wires
	////////////////////////////////////////

	// Issue stage
	logic                 id_valid;
	logic [reg_idx_w-1:0] id_ra;
	logic [reg_idx_w-1:0] id_rb;
	logic [reg_idx_w-1:0] id_rd;
	alu_op_e              id_op;
	logic                 id_uses_imm;
	logic [DATA_W-1:0]    simm;
	logic                 id_freeze;
	logic                 ex_freeze;
	logic                 stall;
	// Register file
	logic [DATA_W-1:0]    rf_dataa;
	logic [DATA_W-1:0]    rf_datab;
	logic                 rf_we;
	logic [reg_idx_w-1:0] rf_waddr;
	logic [DATA_W-1:0]    rf_wdata;
	// Forwarding
	opnd_sel_e            sel_a;
	opnd_sel_e            sel_b;
	logic [DATA_W-1:0]    ex_forw;
	logic [DATA_W-1:0]    wb_forw;
	logic [reg_idx_w-1:0] ex_rd;
	logic                 ex_valid;
	logic [reg_idx_w-1:0] wb_rd;
	logic                 wb_valid;
	// Registered operands
	logic [DATA_W-1:0]    operand_a;
	logic [DATA_W-1:0]    operand_b;

	////////////////////////////////////////
	// Instances
	////////////////////////////////////////

	opx_issue_stage #(.DATA_W(DATA_W)) i_issue (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.stall(stall),
		.id_valid(id_valid), .id_ra(id_ra), .id_rb(id_rb), .id_rd(id_rd),
		.id_op(id_op), .id_uses_imm(id_uses_imm), .simm(simm),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze)
	);

	opx_regfile #(.DATA_W(DATA_W)) i_regfile (
		.clk(clk), .rst_n(rst_n),
		.ra(id_ra), .rb(id_rb), .rf_dataa(rf_dataa), .rf_datab(rf_datab),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	// Pure compare logic, no data path
	opx_fwd_ctrl i_fwd_ctrl (
		.id_ra(id_ra), .id_rb(id_rb), .id_uses_imm(id_uses_imm),
		.ex_rd(ex_rd), .ex_valid(ex_valid), .wb_rd(wb_rd), .wb_valid(wb_valid),
		.sel_a(sel_a), .sel_b(sel_b)
	);

	opx_operand_mux #(.DATA_W(DATA_W)) i_operand_mux (
		.clk(clk), .rst_n(rst_n),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .simm(simm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	opx_exec_stage #(.DATA_W(DATA_W)) i_exec (
		.clk(clk), .rst_n(rst_n),
		.operand_a(operand_a), .operand_b(operand_b),
		.id_valid(id_valid), .id_rd(id_rd), .id_op(id_op), .ex_freeze(ex_freeze),
		.ex_forw(ex_forw), .wb_forw(wb_forw),
		.ex_rd(ex_rd), .ex_valid(ex_valid), .wb_rd(wb_rd), .wb_valid(wb_valid),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_result(out_result), .out_rd(out_rd), .stall(stall),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
	);

endmodule

/* hdl/opx_exec_stage.sv */
// Execute stage with ALU, write-back register, output handshake and register write
`timescale 1ns/10ps

module opx_exec_stage #(
	parameter int DATA_W = opx_pkg::data_w
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Registered operands
	input  logic [DATA_W-1:0]             operand_a,
	input  logic [DATA_W-1:0]             operand_b,
	// Instruction leaving issue
	input  logic                          id_valid,
	input  logic [opx_pkg::reg_idx_w-1:0] id_rd,
	input  opx_pkg::alu_op_e              id_op,
	input  logic                          ex_freeze,
	// Forwarded values
	output logic [DATA_W-1:0]             ex_forw,
	output logic [DATA_W-1:0]             wb_forw,
	// Pending destinations
	output logic [opx_pkg::reg_idx_w-1:0] ex_rd,
	output logic                          ex_valid,
	output logic [opx_pkg::reg_idx_w-1:0] wb_rd,
	output logic                          wb_valid,
	// Output handshake
	output logic                          out_valid,
	input  logic                          out_ready,
	output logic [DATA_W-1:0]             out_result,
	output logic [opx_pkg::reg_idx_w-1:0] out_rd,
	output logic                          stall,
	// Register file write
	output logic                          rf_we,
	output logic [opx_pkg::reg_idx_w-1:0] rf_waddr,
	output logic [DATA_W-1:0]             rf_wdata
);
	import opx_pkg::*;

	alu_op_e           ex_op;
	logic [DATA_W-1:0] wb_result;
	logic              out_fire;

	////////////////////////////////////////
	// Execute control
	////////////////////////////////////////

	// Follows the operand registers, bubbles carry ex_valid low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_rd    <= '0;
			ex_op    <= alu_add;
		end else if (!ex_freeze) begin
			ex_valid <= id_valid;
			ex_rd    <= id_rd;
			ex_op    <= id_op;
		end
	end

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		ex_forw = '0;
		case (ex_op)
			alu_add, alu_addi: ex_forw = operand_a + operand_b;
			alu_sub:           ex_forw = operand_a - operand_b;
			alu_and:           ex_forw = operand_a & operand_b;
			alu_or, alu_ori:   ex_forw = operand_a | operand_b;
			alu_xor:           ex_forw = operand_a ^ operand_b;
			// Shift amount from the low bits of b
			alu_sll:           ex_forw = operand_a << operand_b[shamt_w-1:0];
			default:           ex_forw = '0;
		endcase
	end

	////////////////////////////////////////
	// Write-back register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_result <= ex_forw;
		end
	end

	assign wb_forw = wb_result;

	////////////////////////////////////////
	// Output handshake and register write
	////////////////////////////////////////

	assign out_valid  = wb_valid;
	assign out_result = wb_result;
	assign out_rd     = wb_rd;

	// Blocked result holds the whole pipeline
	assign stall    = out_valid && !out_ready;
	assign out_fire = out_valid && out_ready;

	// Committed on the leaving edge, register zero never written
	assign rf_we    = out_fire && (wb_rd != '0);
	assign rf_waddr = wb_rd;
	assign rf_wdata = wb_result;

endmodule

/* hdl/opx_operand_mux.sv */
// Operand muxes feeding the execute stage and the operand registers under freeze
`timescale 1ns/10ps

module opx_operand_mux #(
	parameter int DATA_W = opx_pkg::data_w
) (
	input  logic               clk,
	input  logic               rst_n,
	// Freezes from issue
	input  logic               id_freeze,
	input  logic               ex_freeze,
	// Candidate operand values
	input  logic [DATA_W-1:0]  rf_dataa,
	input  logic [DATA_W-1:0]  rf_datab,
	input  logic [DATA_W-1:0]  ex_forw,
	input  logic [DATA_W-1:0]  wb_forw,
	input  logic [DATA_W-1:0]  simm,
	// Selects from forwarding control
	input  opx_pkg::opnd_sel_e sel_a,
	input  opx_pkg::opnd_sel_e sel_b,
	// Registered operands
	output logic [DATA_W-1:0]  operand_a,
	output logic [DATA_W-1:0]  operand_b
);
	import opx_pkg::*;

	logic [DATA_W-1:0] muxed_a;
	logic [DATA_W-1:0] muxed_b;
	// Operands already captured for an empty issue slot
	logic              saved;

	////////////////////////////////////////
	// Operand A mux
	////////////////////////////////////////

	// No immediate on this side
	always_comb begin
		case (sel_a)
			sel_ex_forw: muxed_a = ex_forw;
			sel_wb_forw: muxed_a = wb_forw;
			default:     muxed_a = rf_dataa;
		endcase
	end

	////////////////////////////////////////
	// Operand B mux
	////////////////////////////////////////

	always_comb begin
		case (sel_b)
			sel_imm:     muxed_b = simm;
			sel_ex_forw: muxed_b = ex_forw;
			sel_wb_forw: muxed_b = wb_forw;
			default:     muxed_b = rf_datab;
		endcase
	end

	////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////

	// Both freezes low: load every cycle and drop the saved flag
	// Issue frozen only: capture once, then hold as a bubble
	// Execute frozen: hold everything
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			saved     <= 1'b0;
		end else if (!ex_freeze) begin
			if (!id_freeze) begin
				operand_a <= muxed_a;
				operand_b <= muxed_b;
				saved     <= 1'b0;
			end else if (!saved) begin
				operand_a <= muxed_a;
				operand_b <= muxed_b;
				saved     <= 1'b1;
			end
		end
	end

endmodule

/* hdl/opx_fwd_ctrl.sv */
// Forwarding control choosing the source of each operand from pending destinations
`timescale 1ns/10ps

module opx_fwd_ctrl (
	// Issuing instruction
	input  logic [opx_pkg::reg_idx_w-1:0] id_ra,
	input  logic [opx_pkg::reg_idx_w-1:0] id_rb,
	input  logic                          id_uses_imm,
	// Instruction in the operand registers
	input  logic [opx_pkg::reg_idx_w-1:0] ex_rd,
	input  logic                          ex_valid,
	// Instruction in the write-back register
	input  logic [opx_pkg::reg_idx_w-1:0] wb_rd,
	input  logic                          wb_valid,
	// Operand selects
	output opx_pkg::opnd_sel_e            sel_a,
	output opx_pkg::opnd_sel_e            sel_b
);
	import opx_pkg::*;

	// Pending destinations that can forward
	logic ex_live;
	logic wb_live;

	// Register zero never forwards
	assign ex_live = ex_valid && (ex_rd != '0);
	assign wb_live = wb_valid && (wb_rd != '0);

	// Execute is younger, so it wins over write-back
	function automatic opnd_sel_e fwd_sel(input logic [reg_idx_w-1:0] src);
		opnd_sel_e sel;
		sel = sel_rf;
		if (ex_live && (ex_rd == src)) begin
			sel = sel_ex_forw;
		end else if (wb_live && (wb_rd == src)) begin
			sel = sel_wb_forw;
		end
		return sel;
	endfunction

	////////////////////////////////////////
	// Select generation
	////////////////////////////////////////

	assign sel_a = fwd_sel(id_ra);

	// Immediate beats any rb match
	always_comb begin
		sel_b = fwd_sel(id_rb);
		if (id_uses_imm) begin
			sel_b = sel_imm;
		end
	end

endmodule

/* hdl/opx_issue_stage.sv */
// Issue stage holding the instruction register, field decode and freeze generation
`timescale 1ns/10ps

module opx_issue_stage #(
	parameter int DATA_W = opx_pkg::data_w
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Input handshake
	input  logic                          in_valid,
	output logic                          in_ready,
	input  logic [opx_pkg::instr_w-1:0]   in_instr,
	// Back-pressure from write-back
	input  logic                          stall,
	// Decoded instruction
	output logic                          id_valid,
	output logic [opx_pkg::reg_idx_w-1:0] id_ra,
	output logic [opx_pkg::reg_idx_w-1:0] id_rb,
	output logic [opx_pkg::reg_idx_w-1:0] id_rd,
	output opx_pkg::alu_op_e              id_op,
	output logic                          id_uses_imm,
	output logic [DATA_W-1:0]             simm,
	// Pipeline freezes
	output logic                          id_freeze,
	output logic                          ex_freeze
);
	import opx_pkg::*;

	logic [instr_w-1:0] instr_q;

	////////////////////////////////////////
	// Instruction register
	////////////////////////////////////////

	// Nothing moves while the output is blocked
	assign in_ready = !stall;

	// Instruction moves on every unstalled cycle
	// Empty slot when no new word arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
			instr_q  <= '0;
		end else if (!stall) begin
			id_valid <= in_valid;
			if (in_valid) begin
				instr_q <= in_instr;
			end
		end
	end

	////////////////////////////////////////
	// Field decode
	////////////////////////////////////////

	assign id_op = alu_op_e'(instr_q[op_msb:op_lsb]);
	assign id_rd = instr_q[rd_msb:rd_lsb];
	assign id_ra = instr_q[ra_msb:ra_lsb];
	assign id_rb = instr_q[rb_msb:rb_lsb];

	// Sign-extend the 14-bit immediate
	assign simm = {{(DATA_W - imm_w){instr_q[imm_msb]}}, instr_q[imm_msb:imm_lsb]};

	// Immediate forms take operand b from simm
	assign id_uses_imm = (id_op == alu_addi) || (id_op == alu_ori);

	////////////////////////////////////////
	// Freezes
	////////////////////////////////////////

	// Execute follows the output back-pressure
	assign ex_freeze = stall;
	// Issue is also frozen when its register is empty
	assign id_freeze = stall || !id_valid;

endmodule

/* hdl/opx_regfile.sv */
// Register file with two combinational read ports and one write port
`timescale 1ns/10ps

module opx_regfile #(
	parameter int DATA_W = opx_pkg::data_w
) (
	input  logic                         clk,
	input  logic                         rst_n,
	// Read ports
	input  logic [opx_pkg::reg_idx_w-1:0] ra,
	input  logic [opx_pkg::reg_idx_w-1:0] rb,
	output logic [DATA_W-1:0]             rf_dataa,
	output logic [DATA_W-1:0]             rf_datab,
	// Write port
	input  logic                         we,
	input  logic [opx_pkg::reg_idx_w-1:0] waddr,
	input  logic [DATA_W-1:0]             wdata
);
	import opx_pkg::*;

	localparam int nregs = 2 ** reg_idx_w;

	// Register zero has no storage
	logic [DATA_W-1:0] regs_q [1:nregs-1];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	// Writes to register zero are dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < nregs; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs_q[waddr] <= wdata;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Old value on a same-cycle write, write-back forwarding covers it
	always_comb begin
		rf_dataa = '0;
		if (ra != '0) begin
			rf_dataa = regs_q[ra];
		end
	end

	always_comb begin
		rf_datab = '0;
		if (rb != '0) begin
			rf_datab = regs_q[rb];
		end
	end

endmodule

/* hdl/opx_pkg.sv */
// Execute pipeline package with widths, instruction fields and encodings
package opx_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Operand and result width, default for every DATA_W
	localparam int data_w = 32;
	// Register index, thirty-two registers
	localparam int reg_idx_w = 5;
	// Instruction word
	localparam int instr_w = 32;
	// Shift amount taken from operand b
	localparam int shamt_w = 5;

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////

	localparam int op_msb = 31;
	localparam int op_lsb = 29;
	localparam int rd_msb = 28;
	localparam int rd_lsb = 24;
	localparam int ra_msb = 23;
	localparam int ra_lsb = 19;
	localparam int rb_msb = 18;
	localparam int rb_lsb = 14;
	// Immediate, sign-extended to the data width
	localparam int imm_msb = 13;
	localparam int imm_lsb = 0;
	localparam int imm_w = imm_msb - imm_lsb + 1;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// ALU opcodes, straight from bits 31 to 29
	typedef enum logic [2:0] {
		alu_add  = 3'd0,
		alu_sub  = 3'd1,
		alu_and  = 3'd2,
		alu_or   = 3'd3,
		alu_xor  = 3'd4,
		alu_sll  = 3'd5,
		alu_addi = 3'd6,
		alu_ori  = 3'd7
	} alu_op_e;

	// Operand source select
	typedef enum logic [1:0] {
		sel_rf      = 2'd0,
		sel_imm     = 2'd1,
		sel_ex_forw = 2'd2,
		sel_wb_forw = 2'd3
	} opnd_sel_e;

endpackage
